// File: Bender.yml
package:
  name: compute_tile

sources:
  - files:
      - hw/wb_pkg.sv
      - hw/tile_pkg.sv
      - hw/tile_bus_arbiter.sv
      - hw/tile_slave_decoder.sv
      - hw/tile_sram.sv
      - hw/tile_bootrom.sv
      - hw/tile_mailbox.sv
      - hw/compute_tile.sv
  - target: test
    files:
      - tb/compute_tile_assert.sv
      - tb/tb_compute_tile.sv

// File: flist.f
hw/wb_pkg.sv
hw/tile_pkg.sv
hw/tile_bus_arbiter.sv
hw/tile_slave_decoder.sv
hw/tile_sram.sv
hw/tile_bootrom.sv
hw/tile_mailbox.sv
hw/compute_tile.sv
tb/compute_tile_assert.sv
tb/tb_compute_tile.sv

// File: hw/compute_tile.sv
//********************
// Compute tile
// Shared bus with arbiter, decoder, local memory,
// mailbox and boot ROM
//********************
`timescale 1ns/1ps
`default_nettype none

module compute_tile
   import wb_pkg::*, tile_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_i,
   input  wb_req_t [NUM_MASTERS-1:0] m_req_i,
   output wb_rsp_t [NUM_MASTERS-1:0] m_rsp_o,
   output logic                      mbox_irq_o
);

   wb_req_t                  bus_req;   // Granted master's request
   wb_rsp_t                  bus_rsp;
   wb_req_t [NUM_SLAVES-1:0] s_req;
   wb_rsp_t [NUM_SLAVES-1:0] s_rsp;

   tile_bus_arbiter u_arbiter (
      .clk       (clk),
      .rst_i     (rst_i),
      .m_req_i   (m_req_i),
      .m_rsp_o   (m_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   tile_slave_decoder u_decoder (
      .clk       (clk),
      .rst_i     (rst_i),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp),
      .s_req_o   (s_req),
      .s_rsp_i   (s_rsp)
   );

   tile_sram u_sram (
      .clk   (clk),
      .rst_i (rst_i),
      .req_i (s_req[SLAVE_MEM]),
      .rsp_o (s_rsp[SLAVE_MEM])
   );

   tile_mailbox u_mailbox (
      .clk   (clk),
      .rst_i (rst_i),
      .req_i (s_req[SLAVE_MBOX]),
      .rsp_o (s_rsp[SLAVE_MBOX]),
      .irq_o (mbox_irq_o)
   );

   tile_bootrom u_bootrom (
      .clk   (clk),
      .rst_i (rst_i),
      .req_i (s_req[SLAVE_BOOT]),
      .rsp_o (s_rsp[SLAVE_BOOT])
   );

endmodule

`default_nettype wire

// File: hw/tile_bootrom.sv
//********************
// Tile boot ROM
// Read-only boot image, writes get err
//********************
`timescale 1ns/1ps
`default_nettype none

module tile_bootrom
   import wb_pkg::*, tile_pkg::*;
(
   input  logic    clk,
   input  logic    rst_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   logic [BOOT_AW-1:0] word_idx;
   logic               req_en;
   logic               ack_q;
   logic               err_q;
   wb_data_t           dat_q;

   assign word_idx = req_i.adr[BOOT_AW+1:2];   // Bits 5..2
   assign req_en   = req_i.cyc & req_i.stb & ~(ack_q | err_q);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req_en & ~req_i.we;
         err_q <= req_en & req_i.we;   // ROM is never written
      end
   end

   always_ff @(posedge clk) begin
      if (req_en) begin
         dat_q <= req_i.we ? '0 : BOOT_IMAGE[word_idx];
      end
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

endmodule

`default_nettype wire

// File: hw/tile_bus_arbiter.sv
//********************
// Tile bus arbiter
// Round-robin choice between the bus masters, forwards
// the granted request and steers the response back
//********************
`timescale 1ns/1ps
`default_nettype none

module tile_bus_arbiter
   import wb_pkg::*, tile_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_i,
   input  wb_req_t [NUM_MASTERS-1:0] m_req_i,
   output wb_rsp_t [NUM_MASTERS-1:0] m_rsp_o,
   output wb_req_t                   bus_req_o,
   input  wb_rsp_t                   bus_rsp_i
);

   typedef enum logic {
      IDLE,
      BUSY
   } arb_state_e;

   arb_state_e  state_q;
   master_idx_t grant_q;      // Current or last served master
   master_idx_t next_grant;
   logic        req_any;
   logic        done;

   assign done = bus_rsp_i.ack | bus_rsp_i.err;

   // Search starts right after the last served master
   always_comb begin
      master_idx_t cand;
      next_grant = grant_q;
      req_any    = 1'b0;
      for (int off = NUM_MASTERS; off >= 1; off--) begin
         cand = master_idx_t'((int'(grant_q) + off) % NUM_MASTERS);
         if (m_req_i[cand].cyc && m_req_i[cand].stb) begin
            next_grant = cand;   // Lowest offset wins
            req_any    = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= IDLE;
         grant_q <= master_idx_t'(NUM_MASTERS - 1);  // Master 0 goes first
      end else begin
         case (state_q)
            IDLE: begin
               if (req_any) begin
                  state_q <= BUSY;
                  grant_q <= next_grant;
               end
            end
            BUSY: begin
               if (done) begin
                  state_q <= IDLE;   // Response passes this cycle
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   assign bus_req_o = (state_q == BUSY) ? m_req_i[grant_q] : '0;

   always_comb begin
      m_rsp_o = '0;
      if (state_q == BUSY) begin
         m_rsp_o[grant_q] = bus_rsp_i;   // Others see zero
      end
   end

endmodule

`default_nettype wire

// File: hw/tile_mailbox.sv
//********************
// Network adapter mailbox
// Word FIFO behind a data and a status register,
// interrupt while words are waiting
//********************
`timescale 1ns/1ps
`default_nettype none

module tile_mailbox
   import wb_pkg::*, tile_pkg::*;
(
   input  logic    clk,
   input  logic    rst_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o,
   output logic    irq_o
);

   wb_data_t              fifo [MBOX_DEPTH];
   logic [MBOX_PTR_W-1:0] wr_ptr_q;
   logic [MBOX_PTR_W-1:0] rd_ptr_q;
   logic [MBOX_CNT_W-1:0] count_q;
   logic                  req_en;
   logic                  is_data;
   logic                  is_stat;
   logic                  push_ok;
   logic                  pop_ok;
   logic                  stat_rd;
   logic                  ack_q;
   logic                  err_q;
   wb_data_t              dat_q;

   assign req_en  = req_i.cyc & req_i.stb & ~(ack_q | err_q);
   assign is_data = (req_i.adr[DEC_LSB-1:0] == MBOX_DATA_OFS);
   assign is_stat = (req_i.adr[DEC_LSB-1:0] == MBOX_STAT_OFS);

   // Full push, empty pop and status write fall through to err
   assign push_ok = req_en & is_data & req_i.we
                    & (count_q != MBOX_CNT_W'(MBOX_DEPTH));
   assign pop_ok  = req_en & is_data & ~req_i.we & (count_q != '0);
   assign stat_rd = req_en & is_stat & ~req_i.we;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         ack_q    <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         ack_q <= push_ok | pop_ok | stat_rd;
         err_q <= req_en & ~(push_ok | pop_ok | stat_rd);
         if (push_ok) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;   // Depth is a power of two
            count_q  <= count_q + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q  <= count_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push_ok) begin
         fifo[wr_ptr_q] <= req_i.dat;
      end
      if (req_en) begin
         dat_q <= pop_ok  ? fifo[rd_ptr_q] :
                  stat_rd ? wb_data_t'(count_q) : '0;
      end
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};
   assign irq_o = (count_q != '0);

endmodule

`default_nettype wire

// File: hw/tile_pkg.sv
//********************
// Compute tile constants
// Memory map, slave indices, memory sizes and
// the boot image of the tile
//********************
`default_nettype none

package tile_pkg;

   localparam int NUM_MASTERS = 2;     // Instruction and data port
   localparam int NUM_SLAVES  = 3;

   typedef logic [1:0] slave_idx_t;
   typedef logic [$clog2(NUM_MASTERS)-1:0] master_idx_t;

   localparam slave_idx_t SLAVE_MEM  = 2'd0;
   localparam slave_idx_t SLAVE_MBOX = 2'd1;
   localparam slave_idx_t SLAVE_BOOT = 2'd2;

   // Slaves are picked by the top address nibble
   localparam int         DEC_LSB    = 28;
   localparam logic [3:0] MEM_MATCH  = 4'h0;
   localparam logic [3:0] MBOX_MATCH = 4'he;
   localparam logic [3:0] BOOT_MATCH = 4'hf;

   localparam int LMEM_WORDS = 256;
   localparam int LMEM_AW    = $clog2(LMEM_WORDS);

   localparam int MBOX_DEPTH = 4;
   localparam int MBOX_PTR_W = $clog2(MBOX_DEPTH);
   localparam int MBOX_CNT_W = $clog2(MBOX_DEPTH + 1);
   localparam logic [DEC_LSB-1:0] MBOX_DATA_OFS = 'h0;  // Push and pop
   localparam logic [DEC_LSB-1:0] MBOX_STAT_OFS = 'h4;  // Fill count

   localparam int BOOT_WORDS = 16;
   localparam int BOOT_AW    = $clog2(BOOT_WORDS);

   // Reset vector stub that jumps into local memory
   localparam logic [31:0] BOOT_IMAGE [BOOT_WORDS] = '{
      32'h1800_0000, 32'ha840_0000, 32'h1820_0000, 32'ha821_0400,
      32'h9c60_0000, 32'h9c80_0100, 32'hd403_0000, 32'h9c63_0004,
      32'he403_2000, 32'h0fff_fffd, 32'h1500_0000, 32'h4400_1000,
      32'h1500_0000, 32'h0000_0000, 32'h1500_0000, 32'hdead_beef
   };

endpackage

`default_nettype wire

// File: hw/tile_slave_decoder.sv
//********************
// Tile slave decoder
// Routes the bus request to one slave by the top address
// nibble, muxes its response, errors unmapped addresses
//********************
`timescale 1ns/1ps
`default_nettype none

module tile_slave_decoder
   import wb_pkg::*, tile_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_i,
   input  wb_req_t                  bus_req_i,
   output wb_rsp_t                  bus_rsp_o,
   output wb_req_t [NUM_SLAVES-1:0] s_req_o,
   input  wb_rsp_t [NUM_SLAVES-1:0] s_rsp_i
);

   slave_idx_t sel;
   logic       hit;
   logic       req_en;
   logic       err_q;     // Own error pulse for unmapped addresses

   assign req_en = bus_req_i.cyc & bus_req_i.stb;

   always_comb begin
      hit = 1'b1;
      sel = SLAVE_MEM;
      case (bus_req_i.adr[WB_AW-1:DEC_LSB])
         MEM_MATCH:  sel = SLAVE_MEM;
         MBOX_MATCH: sel = SLAVE_MBOX;
         BOOT_MATCH: sel = SLAVE_BOOT;
         default:    hit = 1'b0;
      endcase
   end

   // Only the selected slave sees cyc and stb
   always_comb begin
      for (int s = 0; s < NUM_SLAVES; s++) begin
         s_req_o[s]     = bus_req_i;
         s_req_o[s].cyc = bus_req_i.cyc & hit & (sel == slave_idx_t'(s));
         s_req_o[s].stb = bus_req_i.stb & hit & (sel == slave_idx_t'(s));
      end
   end

   // Same one-cycle latency as a slave, no second pulse
   always_ff @(posedge clk) begin
      if (rst_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req_en & ~hit & ~err_q;
      end
   end

   always_comb begin
      if (hit) begin
         bus_rsp_o = s_rsp_i[sel];
      end else begin
         bus_rsp_o = '{dat: '0, ack: 1'b0, err: err_q};
      end
   end

endmodule

`default_nettype wire

// File: hw/tile_sram.sv
//********************
// Tile local memory
// Word-addressed data memory with byte-select writes
//********************
`timescale 1ns/1ps
`default_nettype none

module tile_sram
   import wb_pkg::*, tile_pkg::*;
(
   input  logic    clk,
   input  logic    rst_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   wb_data_t             mem [LMEM_WORDS];
   logic [LMEM_AW-1:0]   word_idx;
   logic                 req_en;
   logic                 ack_q;
   wb_data_t             dat_q;

   assign word_idx = req_i.adr[LMEM_AW+1:2];          // Bits 9..2
   assign req_en   = req_i.cyc & req_i.stb & ~ack_q;   // No re-ack

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req_en;
      end
   end

   always_ff @(posedge clk) begin
      if (req_en) begin
         dat_q <= mem[word_idx];
         if (req_i.we) begin
            for (int b = 0; b < WB_SW; b++) begin
               if (req_i.sel[b]) begin
                  mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end
      end
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q, err: 1'b0};

endmodule

`default_nettype wire

// File: hw/wb_pkg.sv
//********************
// Wishbone bus types
// Widths, vector types and the request and response
// structs shared by every block on the tile bus
//********************
`default_nettype none

package wb_pkg;

   localparam int WB_AW = 32;          // Byte address
   localparam int WB_DW = 32;
   localparam int WB_SW = WB_DW / 8;   // One select bit per byte

   typedef logic [WB_AW-1:0] wb_addr_t;
   typedef logic [WB_DW-1:0] wb_data_t;
   typedef logic [WB_SW-1:0] wb_sel_t;

   // Master to slave, held stable until ack or err
   typedef struct packed {
      wb_addr_t adr;
      wb_data_t dat;
      wb_sel_t  sel;
      logic     we;
      logic     cyc;
      logic     stb;
   } wb_req_t;

   // Slave to master, at most one of ack and err per cycle
   typedef struct packed {
      wb_data_t dat;
      logic     ack;
      logic     err;
   } wb_rsp_t;

endpackage

`default_nettype wire

// File: tb/compute_tile_assert.sv
//********************
// Tile bus assertions
// Response rules as seen by the bus masters
//********************
`timescale 1ns/1ps
`default_nettype none

module compute_tile_assert
   import wb_pkg::*, tile_pkg::*;
(
   input logic                      clk,
   input logic                      rst_i,
   input wb_rsp_t [NUM_MASTERS-1:0] m_rsp_i
);

   logic [NUM_MASTERS-1:0] ack_v;
   logic [NUM_MASTERS-1:0] err_v;
   logic [NUM_MASTERS-1:0] done;   // Transfer ends for this master
   int                     fail_cnt = 0;

   for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master
      assign ack_v[m] = m_rsp_i[m].ack;
      assign err_v[m] = m_rsp_i[m].err;
   end
   assign done = ack_v | err_v;

   ack_err_excl: assert property (@(posedge clk) disable iff (rst_i)
      !(|(ack_v & err_v)))
      else begin $error("ack and err high together"); fail_cnt++; end

   one_cycle_rsp: assert property (@(posedge clk) disable iff (rst_i)
      !(|(done & $past(done))))
      else begin $error("response held for more than one cycle"); fail_cnt++; end

   single_master_rsp: assert property (@(posedge clk) disable iff (rst_i)
      $onehot0(done))
      else begin $error("both masters answered in one cycle"); fail_cnt++; end

endmodule

bind compute_tile compute_tile_assert u_assert (
   .clk     (clk),
   .rst_i   (rst_i),
   .m_rsp_i (m_rsp_o)
);

`default_nettype wire

// File: tb/tb_compute_tile.sv
//********************
// Compute tile testbench
// Two bus masters, a reference model of memory, mailbox,
// boot ROM and decode, and a compare process
//********************
`timescale 1ns/1ps
`default_nettype none

module tb_compute_tile
   import wb_pkg::*, tile_pkg::*;
();

   localparam int TIMEOUT = 100;   // Cycles per wait

   logic                      clk;
   logic                      rst_i;
   wb_req_t [NUM_MASTERS-1:0] m_req;
   wb_rsp_t [NUM_MASTERS-1:0] m_rsp;
   logic                      mbox_irq;

   logic [31:0]            rng_state = 32'h09a9_ec66;
   wb_data_t               ref_mem [LMEM_WORDS];
   wb_data_t               ref_fifo [$];
   wb_req_t                obs_req_q [$];   // Completed transfers in bus order
   wb_rsp_t                obs_rsp_q [$];
   logic [NUM_MASTERS-1:0] pend;
   int                     skips [NUM_MASTERS];   // Turns lost while waiting
   int                     issued;
   int                     compared;

   compute_tile dut (
      .clk        (clk),
      .rst_i      (rst_i),
      .m_req_i    (m_req),
      .m_rsp_o    (m_rsp),
      .mbox_irq_o (mbox_irq)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function logic [31:0] rand_word();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Expected response of one transfer with the model updated in bus order
   function wb_rsp_t ref_xfer(input wb_req_t req);
      wb_rsp_t     exp;
      logic [27:0] ofs;
      int          idx;
      exp = '0;
      ofs = req.adr[27:0];
      case (req.adr[31:28])
         MEM_MATCH: begin
            idx     = int'(req.adr[9:2]);
            exp.ack = 1'b1;
            exp.dat = ref_mem[idx];
            for (int b = 0; b < 4; b++) begin
               if (req.we && req.sel[b]) ref_mem[idx][8*b +: 8] = req.dat[8*b +: 8];
            end
         end
         MBOX_MATCH: begin
            if (ofs == 28'h0 && req.we && ref_fifo.size() < MBOX_DEPTH) begin
               exp.ack = 1'b1;
               ref_fifo.push_back(req.dat);
            end else if (ofs == 28'h0 && !req.we && ref_fifo.size() > 0) begin
               exp.ack = 1'b1;
               exp.dat = ref_fifo.pop_front();
            end else if (ofs == 28'h4 && !req.we) begin
               exp.ack = 1'b1;
               exp.dat = 32'(ref_fifo.size());
            end else begin
               exp.err = 1'b1;   // Full push, empty pop, bad offset
            end
         end
         BOOT_MATCH: begin
            exp.ack = !req.we;
            exp.err = req.we;
            if (!req.we) exp.dat = BOOT_IMAGE[req.adr[5:2]];
         end
         default: exp.err = 1'b1;
      endcase
      return exp;
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
         $display("tests failed");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   task automatic bus_xfer(input int m, input wb_addr_t adr, input wb_data_t dat,
                           input wb_sel_t sel, input logic we);
      wb_rsp_t rsp;
      int      cycles;
      int      o;
      o      = (m + 1) % NUM_MASTERS;
      cycles = 0;
      @(posedge clk);
      m_req[m] <= '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      pend[m]  = 1'b1;
      skips[m] = 0;
      do begin
         @(negedge clk);
         rsp = m_rsp[m];
         cycles++;
         if (!(rsp.ack || rsp.err) && cycles > TIMEOUT) begin
            $display("Timeout: master %0d got no ack or err for address %h", m, adr);
            $display("tests failed");
            $fatal(1, "Transfer timed out");
         end
      end while (!(rsp.ack || rsp.err));
      obs_req_q.push_back(m_req[m]);
      obs_rsp_q.push_back(rsp);
      check_value($sformatf("data to master %0d while %0d is answered", o, m),
                  m_rsp[o].dat, 0);
      issued++;
      pend[m] = 1'b0;
      if (pend[o]) skips[o]++;
      if (skips[o] > 1) begin
         check_value($sformatf("transfers served while master %0d waits", o), skips[o], 1);
      end
      @(posedge clk);
      m_req[m] <= '0;   // Idle for at least one cycle
   endtask

   initial begin
      wb_req_t req;
      wb_rsp_t got;
      wb_rsp_t exp;
      forever begin
         @(negedge clk);
         if (dut.u_assert.fail_cnt != 0) begin
            $display("Bus handshake assertion failed before time %0t", $time);
            $display("tests failed");
            $fatal(1, "Assertion failure during the run");
         end
         while (obs_req_q.size() > 0) begin
            req = obs_req_q.pop_front();
            got = obs_rsp_q.pop_front();
            exp = ref_xfer(req);
            check_value($sformatf("ack at %h", req.adr), got.ack, exp.ack);
            check_value($sformatf("err at %h", req.adr), got.err, exp.err);
            if (!req.we || exp.err) begin
               check_value($sformatf("data at %h", req.adr), got.dat, exp.dat);
            end
            compared++;
         end
      end
   end

   initial begin
      wb_addr_t adr;
      wb_data_t data [16];
      int       drain;
      rst_i = 1'b1;
      m_req = '0;
      pend  = '0;
      repeat (16) @(posedge clk);
      rst_i <= 1'b0;
      @(negedge clk);
      check_value("responses and irq after reset",
                  {m_rsp[0].ack, m_rsp[0].err, m_rsp[1].ack, m_rsp[1].err, mbox_irq}, 0);

      for (int i = 0; i < 16; i++) begin   // Whole words first at word index i*13
         bus_xfer(i % 2, wb_addr_t'(i * 52), rand_word(), 4'hf, 1'b1);
      end
      for (int i = 0; i < 48; i++) begin
         adr = wb_addr_t'((rand_word() % 16) * 52);
         bus_xfer(i % 2, adr, rand_word(), wb_sel_t'(rand_word()), 1'b1);
      end
      for (int i = 0; i < 16; i++) begin
         bus_xfer((i + 1) % 2, wb_addr_t'(i * 52), '0, 4'hf, 1'b0);
      end

      for (int i = 0; i < BOOT_WORDS; i++) begin
         bus_xfer(i % 2, {BOOT_MATCH, 28'(i * 4)}, '0, 4'hf, 1'b0);
      end
      bus_xfer(0, {BOOT_MATCH, 28'h8}, rand_word(), 4'hf, 1'b1);

      for (int i = 0; i < MBOX_DEPTH; i++) begin
         bus_xfer(i % 2, {MBOX_MATCH, 28'h0}, rand_word(), 4'hf, 1'b1);
      end
      bus_xfer(0, {MBOX_MATCH, 28'h4}, '0, 4'hf, 1'b0);   // Count of 4
      @(negedge clk);
      check_value("irq with words waiting", mbox_irq, 1);
      bus_xfer(1, {MBOX_MATCH, 28'h0}, rand_word(), 4'hf, 1'b1);
      for (int i = 0; i < MBOX_DEPTH; i++) begin
         bus_xfer(i % 2, {MBOX_MATCH, 28'h0}, '0, 4'hf, 1'b0);
      end
      @(negedge clk);
      check_value("irq with an empty mailbox", mbox_irq, 0);
      bus_xfer(1, {MBOX_MATCH, 28'h0}, '0, 4'hf, 1'b0);
      bus_xfer(0, {MBOX_MATCH, 28'h4}, rand_word(), 4'hf, 1'b1);

      bus_xfer(0, 32'h5000_0010, rand_word(), 4'hf, 1'b1);
      bus_xfer(1, 32'h5000_0010, '0, 4'hf, 1'b0);

      for (int i = 0; i < 16; i++) data[i] = rand_word();
      fork
         for (int k = 0; k < 8; k++) begin
            bus_xfer(0, wb_addr_t'((100 + k) * 4), data[k], 4'hf, 1'b1);
            bus_xfer(0, wb_addr_t'((100 + k) * 4), '0, 4'hf, 1'b0);
         end
         for (int k = 0; k < 8; k++) begin
            bus_xfer(1, wb_addr_t'((120 + k) * 4), data[k + 8], 4'hf, 1'b1);
            bus_xfer(1, {BOOT_MATCH, 28'(k * 4)}, '0, 4'hf, 1'b0);
         end
      join

      drain = 0;
      while (obs_req_q.size() > 0 && drain < TIMEOUT) begin
         @(negedge clk);
         drain++;
      end
      check_value("transfers compared", compared, issued);
      if (dut.u_assert.fail_cnt == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("Bus handshake assertions fired %0d times", dut.u_assert.fail_cnt);
         $display("tests failed");
         $fatal(1, "Assertion failures during the run");
      end
   end

endmodule

`default_nettype wire
